// File: design/rt_pkg.sv
package rt_pkg;

  // axi address and config data
  typedef logic [31:0] rt_addr_t;
  typedef logic [31:0] rt_data_t;

  // burst shape
  typedef logic [7:0]  rt_len_t;
  typedef logic [2:0]  rt_size_t;

  // up to one 4 KiB burst
  typedef logic [12:0] rt_bytes_t;

  typedef logic [31:0] rt_budget_t;

  // one region with an inclusive last address
  typedef struct packed {
    rt_addr_t   base;
    rt_addr_t   last;
    rt_budget_t budget;
    rt_budget_t period;
  } rt_region_t;

  typedef enum logic {
    CHAN_AW = 1'b0,
    CHAN_AR = 1'b1
  } rt_chan_e;

  typedef enum logic [1:0] {
    FIELD_BASE   = 2'd0,
    FIELD_LAST   = 2'd1,
    FIELD_BUDGET = 2'd2,
    FIELD_PERIOD = 2'd3
  } rt_field_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } rt_resp_e;

  // config port sequencing
  typedef enum logic {
    WR_IDLE,
    WR_RESP
  } rt_wr_state_e;

  typedef enum logic {
    RD_IDLE,
    RD_RESP
  } rt_rd_state_e;

  // bytes between region register blocks
  localparam int RegionStride = 16;

  // region index width of at least one bit
  function automatic int rt_idx_width(int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

endpackage

// File: design/rt_if.sv
`timescale 1ns/1ps

interface rt_req_if import rt_pkg::*; #(
  parameter int NumRegions = 4
) ();

  localparam int RegionW = rt_idx_width(NumRegions);

  // selected request
  logic               valid;
  rt_chan_e           chan;
  logic               hit;
  logic [RegionW-1:0] region;
  rt_bytes_t          bytes;

  // admitted master handshake
  logic               fire;

  modport decode (
    output valid, chan, hit, region, bytes,
    input  fire
  );

  modport counter (
    input hit, region, bytes, fire
  );

  modport gate (
    input  valid, chan, hit, region,
    output fire
  );

endinterface

// File: design/rt_cfg_regs.sv
`timescale 1ns/1ps

module rt_cfg_regs import rt_pkg::*; #(
  parameter int NumRegions = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  rt_addr_t                    cfg_awaddr_i,
  input  logic                        cfg_awvalid_i,
  output logic                        cfg_awready_o,
  input  rt_data_t                    cfg_wdata_i,
  input  logic [3:0]                  cfg_wstrb_i,
  input  logic                        cfg_wvalid_i,
  output logic                        cfg_wready_o,
  output rt_resp_e                    cfg_bresp_o,
  output logic                        cfg_bvalid_o,
  input  logic                        cfg_bready_i,
  input  rt_addr_t                    cfg_araddr_i,
  input  logic                        cfg_arvalid_i,
  output logic                        cfg_arready_o,
  output rt_data_t                    cfg_rdata_o,
  output rt_resp_e                    cfg_rresp_o,
  output logic                        cfg_rvalid_o,
  input  logic                        cfg_rready_i,
  output rt_region_t [NumRegions-1:0] region_cfg_o,
  output logic [NumRegions-1:0]       restart_o
);

  localparam int RegionW = rt_idx_width(NumRegions);
  localparam rt_addr_t SpaceEnd = rt_addr_t'(NumRegions * RegionStride);

  rt_wr_state_e wr_state_q;
  rt_rd_state_e rd_state_q;
  logic aw_have_q, w_have_q;
  rt_addr_t awaddr_q;
  rt_data_t wdata_q;
  logic [3:0] wstrb_q;
  rt_resp_e bresp_q, rresp_q;
  rt_data_t rdata_q;
  rt_region_t [NumRegions-1:0] region_q;
  logic [NumRegions-1:0] restart_q;

  logic aw_hs, w_hs, wr_go, ar_hs;
  rt_addr_t wr_addr;
  rt_data_t wr_data, wr_new;
  logic [3:0] wr_strb;
  logic wr_in_range, rd_in_range;
  logic [RegionW-1:0] wr_idx, rd_idx;
  rt_field_e wr_field, rd_field;

  function automatic rt_data_t field_value(rt_region_t r, rt_field_e f);
    rt_data_t v;
    case (f)
      FIELD_BASE:   v = r.base;
      FIELD_LAST:   v = r.last;
      FIELD_BUDGET: v = r.budget;
      default:      v = r.period;
    endcase
    return v;
  endfunction

  // byte-wise merge under wstrb
  function automatic rt_data_t merge_bytes(rt_data_t old_v, rt_data_t new_v, logic [3:0] strb);
    rt_data_t res;
    res = old_v;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_v[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign cfg_awready_o = (wr_state_q == WR_IDLE) && !aw_have_q;
  assign cfg_wready_o  = (wr_state_q == WR_IDLE) && !w_have_q;
  assign cfg_bvalid_o  = (wr_state_q == WR_RESP);
  assign cfg_bresp_o   = bresp_q;
  assign cfg_arready_o = (rd_state_q == RD_IDLE);
  assign cfg_rvalid_o  = (rd_state_q == RD_RESP);
  assign cfg_rdata_o   = rdata_q;
  assign cfg_rresp_o   = rresp_q;
  assign region_cfg_o  = region_q;
  assign restart_o     = restart_q;

  assign aw_hs = cfg_awvalid_i && cfg_awready_o;
  assign w_hs  = cfg_wvalid_i && cfg_wready_o;
  assign ar_hs = cfg_arvalid_i && cfg_arready_o;
  // both halves present as stored or arriving now
  assign wr_go = (wr_state_q == WR_IDLE) && (aw_hs || aw_have_q) && (w_hs || w_have_q);

  assign wr_addr     = aw_hs ? cfg_awaddr_i : awaddr_q;
  assign wr_data     = w_hs ? cfg_wdata_i : wdata_q;
  assign wr_strb     = w_hs ? cfg_wstrb_i : wstrb_q;
  assign wr_in_range = wr_addr < SpaceEnd;
  assign wr_idx      = wr_addr[RegionW+3:4];
  assign wr_field    = rt_field_e'(wr_addr[3:2]);
  assign wr_new      = merge_bytes(field_value(region_q[wr_idx], wr_field), wr_data, wr_strb);

  assign rd_in_range = cfg_araddr_i < SpaceEnd;
  assign rd_idx      = cfg_araddr_i[RegionW+3:4];
  assign rd_field    = rt_field_e'(cfg_araddr_i[3:2]);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_state_q <= WR_IDLE;
      rd_state_q <= RD_IDLE;
      aw_have_q  <= 1'b0;
      w_have_q   <= 1'b0;
      restart_q  <= '0;
      // empty match range until configured
      for (int r = 0; r < NumRegions; r++) begin
        region_q[r] <= '{base: '1, last: '0, budget: '0, period: '0};
      end
    end else begin
      restart_q <= '0;
      case (wr_state_q)
        WR_IDLE: begin
          if (wr_go) begin
            wr_state_q <= WR_RESP;
            aw_have_q  <= 1'b0;
            w_have_q   <= 1'b0;
            if (wr_in_range) begin
              restart_q[wr_idx] <= 1'b1;
              case (wr_field)
                FIELD_BASE:   region_q[wr_idx].base   <= wr_new;
                FIELD_LAST:   region_q[wr_idx].last   <= wr_new;
                FIELD_BUDGET: region_q[wr_idx].budget <= wr_new;
                default:      region_q[wr_idx].period <= wr_new;
              endcase
            end
          end else begin
            if (aw_hs) aw_have_q <= 1'b1;
            if (w_hs) w_have_q <= 1'b1;
          end
        end
        default: begin
          if (cfg_bready_i) wr_state_q <= WR_IDLE;
        end
      endcase
      case (rd_state_q)
        RD_IDLE: if (ar_hs) rd_state_q <= RD_RESP;
        default: if (cfg_rready_i) rd_state_q <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) awaddr_q <= cfg_awaddr_i;
    if (w_hs) begin
      wdata_q <= cfg_wdata_i;
      wstrb_q <= cfg_wstrb_i;
    end
    if (wr_go) bresp_q <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
    if (ar_hs) begin
      rresp_q <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
      rdata_q <= rd_in_range ? field_value(region_q[rd_idx], rd_field) : '0;
    end
  end

  // no half of the next write is taken while B is pending
  a_no_half_during_b: assert property (@(posedge clk_i) disable iff (rst_i)
    cfg_bvalid_o |-> !aw_have_q && !w_have_q);

endmodule

// File: design/rt_req_decode.sv
`timescale 1ns/1ps

module rt_req_decode import rt_pkg::*; #(
  parameter int NumRegions = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  rt_addr_t                    slv_aw_addr_i,
  input  rt_len_t                     slv_aw_len_i,
  input  rt_size_t                    slv_aw_size_i,
  input  logic                        slv_aw_valid_i,
  input  rt_addr_t                    slv_ar_addr_i,
  input  rt_len_t                     slv_ar_len_i,
  input  rt_size_t                    slv_ar_size_i,
  input  logic                        slv_ar_valid_i,
  input  rt_region_t [NumRegions-1:0] region_cfg_i,
  rt_req_if.decode                    req
);

  localparam int RegionW = rt_idx_width(NumRegions);

  rt_chan_e rr_q, sel_q, chan;
  logic held_q;
  rt_addr_t sel_addr;
  rt_len_t sel_len;
  rt_size_t sel_size;
  logic [15:0] beats;

  // a held request keeps its channel until it fires
  always_comb begin
    if (held_q) begin
      chan = sel_q;
    end else if (slv_aw_valid_i && slv_ar_valid_i) begin
      chan = rr_q;
    end else if (slv_ar_valid_i) begin
      chan = CHAN_AR;
    end else begin
      chan = CHAN_AW;
    end
  end

  assign sel_addr = (chan == CHAN_AW) ? slv_aw_addr_i : slv_ar_addr_i;
  assign sel_len  = (chan == CHAN_AW) ? slv_aw_len_i : slv_ar_len_i;
  assign sel_size = (chan == CHAN_AW) ? slv_aw_size_i : slv_ar_size_i;
  assign beats    = {8'd0, sel_len} + 16'd1;

  assign req.chan  = chan;
  assign req.valid = (chan == CHAN_AW) ? slv_aw_valid_i : slv_ar_valid_i;
  assign req.bytes = rt_bytes_t'(beats << sel_size);

  // lowest matching region wins
  always_comb begin
    req.hit    = 1'b0;
    req.region = '0;
    for (int i = NumRegions - 1; i >= 0; i--) begin
      if (region_cfg_i[i].base <= sel_addr && region_cfg_i[i].last >= sel_addr) begin
        req.hit    = 1'b1;
        req.region = RegionW'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q   <= CHAN_AW;
      sel_q  <= CHAN_AW;
      held_q <= 1'b0;
    end else begin
      sel_q  <= chan;
      held_q <= req.valid && !req.fire;
      // prefer the other channel after a grant
      if (req.fire) begin
        rr_q <= (chan == CHAN_AW) ? CHAN_AR : CHAN_AW;
      end
    end
  end

  a_chan_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    req.valid && !req.fire |=> $stable(req.chan));

endmodule

// File: design/rt_budget_counter.sv
`timescale 1ns/1ps

module rt_budget_counter import rt_pkg::*; #(
  parameter int NumRegions = 4,
  parameter int Index      = 0
) (
  input  logic       clk_i,
  input  logic       rst_i,
  input  rt_region_t region_cfg_i,
  input  logic       restart_i,
  rt_req_if.counter  req,
  output logic       budget_ok_o
);

  localparam int RegionW = rt_idx_width(NumRegions);

  rt_budget_t cnt_q;
  rt_budget_t remain_q, remain_d;
  rt_budget_t base, spend, req_bytes;
  logic refill, fire_here;

  assign req_bytes = rt_budget_t'(req.bytes);
  assign fire_here = req.fire && req.hit && (req.region == RegionW'(Index));
  // period rollover or a config write
  assign refill    = restart_i || (cnt_q == region_cfg_i.period);

  // subtract what fired this cycle and floor at zero
  always_comb begin
    base     = refill ? region_cfg_i.budget : remain_q;
    spend    = fire_here ? req_bytes : '0;
    remain_d = (spend > base) ? '0 : base - spend;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q    <= '0;
      remain_q <= '0;
    end else begin
      cnt_q    <= refill ? '0 : cnt_q + rt_budget_t'(1);
      remain_q <= remain_d;
    end
  end

  // fresh budget admits one oversize burst
  assign budget_ok_o = (req_bytes <= remain_q) || (remain_q == region_cfg_i.budget);

  // a lowered budget is caught by the restart that comes with it
  a_remain_bounded: assert property (@(posedge clk_i) disable iff (rst_i)
    !restart_i |-> remain_q <= region_cfg_i.budget);

endmodule

// File: design/rt_channel_gate.sv
`timescale 1ns/1ps

module rt_channel_gate import rt_pkg::*; #(
  parameter int NumRegions = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  rt_req_if.gate                req,
  input  logic [NumRegions-1:0] budget_ok_i,
  input  rt_addr_t              slv_aw_addr_i,
  input  rt_len_t               slv_aw_len_i,
  input  rt_size_t              slv_aw_size_i,
  output logic                  slv_aw_ready_o,
  input  rt_addr_t              slv_ar_addr_i,
  input  rt_len_t               slv_ar_len_i,
  input  rt_size_t              slv_ar_size_i,
  output logic                  slv_ar_ready_o,
  output rt_addr_t              mst_aw_addr_o,
  output rt_len_t               mst_aw_len_o,
  output rt_size_t              mst_aw_size_o,
  output logic                  mst_aw_valid_o,
  input  logic                  mst_aw_ready_i,
  output rt_addr_t              mst_ar_addr_o,
  output rt_len_t               mst_ar_len_o,
  output rt_size_t              mst_ar_size_o,
  output logic                  mst_ar_valid_o,
  input  logic                  mst_ar_ready_i
);

  logic admit;

  // unmatched traffic is never throttled
  assign admit = req.valid && (!req.hit || budget_ok_i[req.region]);

  assign mst_aw_valid_o = admit && (req.chan == CHAN_AW);
  assign mst_ar_valid_o = admit && (req.chan == CHAN_AR);

  assign mst_aw_addr_o = slv_aw_addr_i;
  assign mst_aw_len_o  = slv_aw_len_i;
  assign mst_aw_size_o = slv_aw_size_i;
  assign mst_ar_addr_o = slv_ar_addr_i;
  assign mst_ar_len_o  = slv_ar_len_i;
  assign mst_ar_size_o = slv_ar_size_i;

  // ready only for the channel being forwarded
  assign slv_aw_ready_o = mst_aw_valid_o && mst_aw_ready_i;
  assign slv_ar_ready_o = mst_ar_valid_o && mst_ar_ready_i;
  assign req.fire       = slv_aw_ready_o || slv_ar_ready_o;

  property p_valid_hold(logic vld, logic rdy, logic [42:0] fields);
    @(posedge clk_i) disable iff (rst_i)
      vld && !rdy |=> vld && $stable(fields);
  endproperty

  a_aw_hold: assert property (p_valid_hold(mst_aw_valid_o, mst_aw_ready_i,
    {mst_aw_addr_o, mst_aw_len_o, mst_aw_size_o}));
  a_ar_hold: assert property (p_valid_hold(mst_ar_valid_o, mst_ar_ready_i,
    {mst_ar_addr_o, mst_ar_len_o, mst_ar_size_o}));

endmodule

// File: design/axi_rt_unit.sv
`timescale 1ns/1ps

module axi_rt_unit import rt_pkg::*; #(
  parameter int NumRegions = 4
) (
  input  logic       clk_i,
  input  logic       rst_i,
  // config port
  input  rt_addr_t   cfg_awaddr_i,
  input  logic       cfg_awvalid_i,
  output logic       cfg_awready_o,
  input  rt_data_t   cfg_wdata_i,
  input  logic [3:0] cfg_wstrb_i,
  input  logic       cfg_wvalid_i,
  output logic       cfg_wready_o,
  output rt_resp_e   cfg_bresp_o,
  output logic       cfg_bvalid_o,
  input  logic       cfg_bready_i,
  input  rt_addr_t   cfg_araddr_i,
  input  logic       cfg_arvalid_i,
  output logic       cfg_arready_o,
  output rt_data_t   cfg_rdata_o,
  output rt_resp_e   cfg_rresp_o,
  output logic       cfg_rvalid_o,
  input  logic       cfg_rready_i,
  // slave side
  input  rt_addr_t   slv_aw_addr_i,
  input  rt_len_t    slv_aw_len_i,
  input  rt_size_t   slv_aw_size_i,
  input  logic       slv_aw_valid_i,
  output logic       slv_aw_ready_o,
  input  rt_addr_t   slv_ar_addr_i,
  input  rt_len_t    slv_ar_len_i,
  input  rt_size_t   slv_ar_size_i,
  input  logic       slv_ar_valid_i,
  output logic       slv_ar_ready_o,
  // master side
  output rt_addr_t   mst_aw_addr_o,
  output rt_len_t    mst_aw_len_o,
  output rt_size_t   mst_aw_size_o,
  output logic       mst_aw_valid_o,
  input  logic       mst_aw_ready_i,
  output rt_addr_t   mst_ar_addr_o,
  output rt_len_t    mst_ar_len_o,
  output rt_size_t   mst_ar_size_o,
  output logic       mst_ar_valid_o,
  input  logic       mst_ar_ready_i
);

  rt_region_t [NumRegions-1:0] region_cfg;
  logic [NumRegions-1:0] restart;
  logic [NumRegions-1:0] budget_ok;

  rt_req_if #(.NumRegions(NumRegions)) req_if ();

  rt_cfg_regs #(.NumRegions(NumRegions)) i_cfg_regs (
    .clk_i, .rst_i,
    .cfg_awaddr_i, .cfg_awvalid_i, .cfg_awready_o,
    .cfg_wdata_i, .cfg_wstrb_i, .cfg_wvalid_i, .cfg_wready_o,
    .cfg_bresp_o, .cfg_bvalid_o, .cfg_bready_i,
    .cfg_araddr_i, .cfg_arvalid_i, .cfg_arready_o,
    .cfg_rdata_o, .cfg_rresp_o, .cfg_rvalid_o, .cfg_rready_i,
    .region_cfg_o (region_cfg),
    .restart_o    (restart)
  );

  rt_req_decode #(.NumRegions(NumRegions)) i_req_decode (
    .clk_i, .rst_i,
    .slv_aw_addr_i, .slv_aw_len_i, .slv_aw_size_i, .slv_aw_valid_i,
    .slv_ar_addr_i, .slv_ar_len_i, .slv_ar_size_i, .slv_ar_valid_i,
    .region_cfg_i (region_cfg),
    .req          (req_if.decode)
  );

  // one budget tracker per region
  for (genvar i = 0; i < NumRegions; i++) begin : g_counter
    rt_budget_counter #(
      .NumRegions (NumRegions),
      .Index      (i)
    ) i_budget_counter (
      .clk_i, .rst_i,
      .region_cfg_i (region_cfg[i]),
      .restart_i    (restart[i]),
      .req          (req_if.counter),
      .budget_ok_o  (budget_ok[i])
    );
  end

  rt_channel_gate #(.NumRegions(NumRegions)) i_channel_gate (
    .clk_i, .rst_i,
    .req         (req_if.gate),
    .budget_ok_i (budget_ok),
    .slv_aw_addr_i, .slv_aw_len_i, .slv_aw_size_i, .slv_aw_ready_o,
    .slv_ar_addr_i, .slv_ar_len_i, .slv_ar_size_i, .slv_ar_ready_o,
    .mst_aw_addr_o, .mst_aw_len_o, .mst_aw_size_o, .mst_aw_valid_o, .mst_aw_ready_i,
    .mst_ar_addr_o, .mst_ar_len_o, .mst_ar_size_o, .mst_ar_valid_o, .mst_ar_ready_i
  );

endmodule

// File: sim/tb_axi_rt_unit.sv
`timescale 1ns/1ps

module tb_axi_rt_unit import rt_pkg::*; ();

  localparam int NumRegions = 4;
  localparam int Timeout    = 1000;
  localparam int HoldWindow = 300;

  logic       clk_i, rst_i;
  rt_addr_t   cfg_awaddr_i, cfg_araddr_i;
  rt_data_t   cfg_wdata_i, cfg_rdata_o;
  logic [3:0] cfg_wstrb_i;
  logic       cfg_awvalid_i, cfg_awready_o, cfg_wvalid_i, cfg_wready_o;
  logic       cfg_bvalid_o, cfg_bready_i, cfg_arvalid_i, cfg_arready_o;
  logic       cfg_rvalid_o, cfg_rready_i;
  rt_resp_e   cfg_bresp_o, cfg_rresp_o;
  rt_addr_t   slv_aw_addr_i, slv_ar_addr_i, mst_aw_addr_o, mst_ar_addr_o;
  rt_len_t    slv_aw_len_i, slv_ar_len_i, mst_aw_len_o, mst_ar_len_o;
  rt_size_t   slv_aw_size_i, slv_ar_size_i, mst_aw_size_o, mst_ar_size_o;
  logic       slv_aw_valid_i, slv_aw_ready_o, slv_ar_valid_i, slv_ar_ready_o;
  logic       mst_aw_valid_o, mst_aw_ready_i, mst_ar_valid_o, mst_ar_ready_i;

  // region model with one word per register field
  rt_data_t   m_cfg [NumRegions][4];
  rt_budget_t m_remain [NumRegions];
  logic [31:0] rng;
  string      test_name;
  logic       aw_busy, ar_busy;
  rt_addr_t   exp_aw_addr, exp_ar_addr, pend_addr;
  rt_len_t    exp_aw_len, exp_ar_len;
  rt_size_t   exp_aw_size, exp_ar_size;
  rt_bytes_t  pend_bytes;

  axi_rt_unit #(.NumRegions(NumRegions)) UUT (.*);

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] next_random(logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // len+1 beats of 2**size bytes
  function automatic rt_bytes_t burst_bytes(rt_len_t len, rt_size_t size);
    int unsigned n;
    n = (int'(len) + 1) << size;
    return rt_bytes_t'(n);
  endfunction

  // lowest matching region or -1 when none
  function automatic int region_of(rt_addr_t addr);
    for (int r = 0; r < NumRegions; r++) begin
      if (m_cfg[r][FIELD_BASE] <= addr && m_cfg[r][FIELD_LAST] >= addr) return r;
    end
    return -1;
  endfunction

  function automatic bit admits(rt_addr_t addr, rt_bytes_t bytes);
    int r;
    r = region_of(addr);
    if (r < 0) return 1'b1;
    return (rt_budget_t'(bytes) <= m_remain[r]) || (m_remain[r] == m_cfg[r][FIELD_BUDGET]);
  endfunction

  function automatic void consume_budget(rt_addr_t addr, rt_bytes_t bytes);
    int r;
    r = region_of(addr);
    if (r < 0) return;
    if (rt_budget_t'(bytes) >= m_remain[r]) begin
      m_remain[r] = '0;
    end else begin
      m_remain[r] = m_remain[r] - rt_budget_t'(bytes);
    end
  endfunction

  function automatic void apply_write(rt_addr_t addr, rt_data_t data, logic [3:0] strb);
    int r;
    int f;
    if (addr >= NumRegions * RegionStride) return;
    r = addr / RegionStride;
    f = addr[3:2];
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) m_cfg[r][f][8*b +: 8] = data[8*b +: 8];
    end
    // any field write restarts the period
    m_remain[r] = m_cfg[r][FIELD_BUDGET];
  endfunction

  task automatic fail_now();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_data(string what, rt_data_t exp, rt_data_t act);
    if (act !== exp) begin
      $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
      fail_now();
    end
  endtask

  task automatic check_resp(string what, rt_resp_e exp, rt_resp_e act);
    if (act !== exp) begin
      $display("Error: %s %s expected %s actual %s", test_name, what, exp.name(), act.name());
      fail_now();
    end
  endtask

  task automatic check_addr(string what, rt_addr_t exp, rt_addr_t act);
    if (act !== exp) begin
      $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
      fail_now();
    end
  endtask

  task automatic check_len(string what, rt_len_t exp, rt_len_t act);
    if (act !== exp) begin
      $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
      fail_now();
    end
  endtask

  task automatic check_size(string what, rt_size_t exp, rt_size_t act);
    if (act !== exp) begin
      $display("Error: %s %s expected %0d actual %0d", test_name, what, exp, act);
      fail_now();
    end
  endtask

  task automatic check_bytes(string what, rt_bytes_t exp, rt_bytes_t act);
    if (act !== exp) begin
      $display("Error: %s %s expected %0d actual %0d", test_name, what, exp, act);
      fail_now();
    end
  endtask

  task automatic check_ready(string what, logic exp, logic act);
    if (act !== exp) begin
      $display("Error: %s %s expected %b actual %b", test_name, what, exp, act);
      fail_now();
    end
  endtask

  task automatic write_register(rt_addr_t addr, rt_data_t data, logic [3:0] strb);
    bit aw_done;
    bit w_done;
    bit b_done;
    rt_resp_e exp_resp;
    exp_resp = (addr < NumRegions * RegionStride) ? RESP_OKAY : RESP_SLVERR;
    apply_write(addr, data, strb);
    cfg_awaddr_i  = addr;
    cfg_awvalid_i = 1'b1;
    cfg_wdata_i   = data;
    cfg_wstrb_i   = strb;
    cfg_wvalid_i  = 1'b1;
    aw_done = 1'b0;
    w_done  = 1'b0;
    for (int n = 0; n < Timeout && !(aw_done && w_done); n++) begin
      @(negedge clk_i);
      if (cfg_awvalid_i && cfg_awready_o) aw_done = 1'b1;
      if (cfg_wvalid_i && cfg_wready_o) w_done = 1'b1;
      @(posedge clk_i);
      #2;
      if (aw_done) cfg_awvalid_i = 1'b0;
      if (w_done) cfg_wvalid_i = 1'b0;
    end
    if (!(aw_done && w_done)) begin
      $display("%s: config write address or data was never accepted", test_name);
      fail_now();
    end
    cfg_bready_i = 1'b1;
    b_done = 1'b0;
    for (int n = 0; n < Timeout && !b_done; n++) begin
      @(negedge clk_i);
      if (cfg_bvalid_o) begin
        check_resp("bresp", exp_resp, cfg_bresp_o);
        b_done = 1'b1;
      end
      @(posedge clk_i);
      #2;
    end
    cfg_bready_i = 1'b0;
    if (!b_done) begin
      $display("%s: no write response arrived", test_name);
      fail_now();
    end
  endtask

  task automatic read_register(rt_addr_t addr, rt_data_t exp_data, rt_resp_e exp_resp);
    bit ar_done;
    bit r_done;
    cfg_araddr_i  = addr;
    cfg_arvalid_i = 1'b1;
    ar_done = 1'b0;
    for (int n = 0; n < Timeout && !ar_done; n++) begin
      @(negedge clk_i);
      if (cfg_arready_o) ar_done = 1'b1;
      @(posedge clk_i);
      #2;
    end
    cfg_arvalid_i = 1'b0;
    if (!ar_done) begin
      $display("%s: config read address was never accepted", test_name);
      fail_now();
    end
    cfg_rready_i = 1'b1;
    r_done = 1'b0;
    for (int n = 0; n < Timeout && !r_done; n++) begin
      @(negedge clk_i);
      if (cfg_rvalid_o) begin
        check_data("rdata", exp_data, cfg_rdata_o);
        check_resp("rresp", exp_resp, cfg_rresp_o);
        r_done = 1'b1;
      end
      @(posedge clk_i);
      #2;
    end
    cfg_rready_i = 1'b0;
    if (!r_done) begin
      $display("%s: config read was not answered", test_name);
      fail_now();
    end
  endtask

  task automatic start_request(rt_chan_e chan, rt_addr_t addr, rt_len_t len, rt_size_t size);
    if (chan == CHAN_AW) begin
      slv_aw_addr_i  = addr;
      slv_aw_len_i   = len;
      slv_aw_size_i  = size;
      slv_aw_valid_i = 1'b1;
      exp_aw_addr = addr;
      exp_aw_len  = len;
      exp_aw_size = size;
      aw_busy     = 1'b1;
    end else begin
      slv_ar_addr_i  = addr;
      slv_ar_len_i   = len;
      slv_ar_size_i  = size;
      slv_ar_valid_i = 1'b1;
      exp_ar_addr = addr;
      exp_ar_len  = len;
      exp_ar_size = size;
      ar_busy     = 1'b1;
    end
    pend_addr  = addr;
    pend_bytes = burst_bytes(len, size);
  endtask

  // random master back-pressure until every pending burst is accepted
  task automatic serve_requests(int limit);
    for (int n = 0; n < limit && (aw_busy || ar_busy); n++) begin
      rng = next_random(rng);
      mst_aw_ready_i = rng[0];
      mst_ar_ready_i = rng[1];
      @(negedge clk_i);
      // the slave handshake must coincide with the master one
      if (aw_busy && slv_aw_ready_o) begin
        check_ready("aw master handshake", 1'b1, mst_aw_valid_o && mst_aw_ready_i);
        check_addr("aw addr", exp_aw_addr, mst_aw_addr_o);
        check_len("aw len", exp_aw_len, mst_aw_len_o);
        check_size("aw size", exp_aw_size, mst_aw_size_o);
        check_bytes("aw bytes", burst_bytes(exp_aw_len, exp_aw_size), UUT.req_if.bytes);
        consume_budget(exp_aw_addr, burst_bytes(exp_aw_len, exp_aw_size));
        aw_busy = 1'b0;
      end else begin
        check_ready("aw master handshake", 1'b0, mst_aw_valid_o && mst_aw_ready_i);
        check_ready("aw slave ready", 1'b0, slv_aw_ready_o);
      end
      if (ar_busy && slv_ar_ready_o) begin
        check_ready("ar master handshake", 1'b1, mst_ar_valid_o && mst_ar_ready_i);
        check_addr("ar addr", exp_ar_addr, mst_ar_addr_o);
        check_len("ar len", exp_ar_len, mst_ar_len_o);
        check_size("ar size", exp_ar_size, mst_ar_size_o);
        check_bytes("ar bytes", burst_bytes(exp_ar_len, exp_ar_size), UUT.req_if.bytes);
        consume_budget(exp_ar_addr, burst_bytes(exp_ar_len, exp_ar_size));
        ar_busy = 1'b0;
      end else begin
        check_ready("ar master handshake", 1'b0, mst_ar_valid_o && mst_ar_ready_i);
        check_ready("ar slave ready", 1'b0, slv_ar_ready_o);
      end
      @(posedge clk_i);
      #2;
      slv_aw_valid_i = aw_busy;
      slv_ar_valid_i = ar_busy;
    end
    mst_aw_ready_i = 1'b0;
    mst_ar_ready_i = 1'b0;
    if (aw_busy || ar_busy) begin
      $display("%s: a burst that should pass never reached the master port", test_name);
      fail_now();
    end
  endtask

  task automatic watch_hold(int window);
    for (int n = 0; n < window; n++) begin
      rng = next_random(rng);
      mst_aw_ready_i = rng[0];
      mst_ar_ready_i = rng[1];
      @(negedge clk_i);
      if ((mst_aw_valid_o && mst_aw_ready_i) || (mst_ar_valid_o && mst_ar_ready_i)) begin
        $display("%s: a burst that should be held was forwarded", test_name);
        fail_now();
      end
      check_ready("aw slave ready", 1'b0, slv_aw_ready_o);
      check_ready("ar slave ready", 1'b0, slv_ar_ready_o);
      @(posedge clk_i);
      #2;
    end
    mst_aw_ready_i = 1'b0;
    mst_ar_ready_i = 1'b0;
  endtask

  initial begin
    int fd;
    int code;
    int line_no;
    logic [63:0] tok, chan_tok, label;
    logic [8*128-1:0] rest;
    rt_addr_t addr, addr2;
    rt_data_t data;
    logic [3:0] strb;
    logic [1:0] resp;
    rt_len_t len;
    rt_size_t size;
    bit pass_pred;

    clk_i = 1'b0;
    rst_i = 1'b1;
    cfg_awaddr_i = '0;
    cfg_awvalid_i = 1'b0;
    cfg_wdata_i = '0;
    cfg_wstrb_i = '0;
    cfg_wvalid_i = 1'b0;
    cfg_bready_i = 1'b0;
    cfg_araddr_i = '0;
    cfg_arvalid_i = 1'b0;
    cfg_rready_i = 1'b0;
    slv_aw_addr_i = '0;
    slv_aw_len_i = '0;
    slv_aw_size_i = '0;
    slv_aw_valid_i = 1'b0;
    slv_ar_addr_i = '0;
    slv_ar_len_i = '0;
    slv_ar_size_i = '0;
    slv_ar_valid_i = 1'b0;
    mst_aw_ready_i = 1'b0;
    mst_ar_ready_i = 1'b0;
    rng = 32'h8366;
    aw_busy = 1'b0;
    ar_busy = 1'b0;
    line_no = 0;
    // reset state matches nothing
    for (int r = 0; r < NumRegions; r++) begin
      m_cfg[r][FIELD_BASE]   = '1;
      m_cfg[r][FIELD_LAST]   = '0;
      m_cfg[r][FIELD_BUDGET] = '0;
      m_cfg[r][FIELD_PERIOD] = '0;
      m_remain[r] = '0;
    end

    repeat (4) @(posedge clk_i);
    #2;
    rst_i = 1'b0;

    fd = $fopen("sim/axi_rt_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file");
      fail_now();
    end
    forever begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) break;
      line_no++;
      test_name = $sformatf("vector %0d (%0s)", line_no, tok);
      if (tok == "#") begin
        code = $fgets(rest, fd);
      end else if (tok == "W") begin
        code = $fscanf(fd, "%h %h %h", addr, data, strb);
        write_register(addr, data, strb);
        // a held burst may now be admitted
        if ((aw_busy || ar_busy) && admits(pend_addr, pend_bytes)) serve_requests(Timeout);
      end else if (tok == "R") begin
        code = $fscanf(fd, "%h %h %h", addr, data, resp);
        read_register(addr, data, rt_resp_e'(resp));
      end else if (tok == "T") begin
        code = $fscanf(fd, "%s %h %h %h %s", chan_tok, addr, len, size, label);
        pass_pred = admits(addr, burst_bytes(len, size));
        if (pass_pred != (label == "PASS")) begin
          $display("%s: the label disagrees with the region model", test_name);
          fail_now();
        end
        start_request((chan_tok == "AR") ? CHAN_AR : CHAN_AW, addr, len, size);
        if (pass_pred) serve_requests(Timeout);
        else watch_hold(HoldWindow);
      end else if (tok == "D") begin
        code = $fscanf(fd, "%h %h %h %h", addr, addr2, len, size);
        if (!admits(addr, burst_bytes(len, size)) || !admits(addr2, burst_bytes(len, size))) begin
          $display("%s: a channel pair must use addresses that pass", test_name);
          fail_now();
        end
        start_request(CHAN_AW, addr, len, size);
        start_request(CHAN_AR, addr2, len, size);
        serve_requests(Timeout);
      end else begin
        $display("%s: unknown vector command", test_name);
        fail_now();
      end
    end
    $fclose(fd);

    if (aw_busy || ar_busy) begin
      $display("%s: a held burst was never released", test_name);
      fail_now();
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

// File: sim/axi_rt_vectors.txt
# W addr data strb | R addr expdata expresp (0 okay, 2 slverr)
# T chan addr len size PASS/HOLD | D aw_addr ar_addr len size
W 0000000c 000186a0 f
W 00000000 10000000 f
W 00000004 10000fff f
R 00000000 10000000 0
R 00000004 10000fff 0
W 00000008 12345678 3
R 00000008 00005678 0
W 00000008 00000100 f
R 00000008 00000100 0
W 00000040 deadbeef f
R 00000040 00000000 2
R 0000007c 00000000 2
# unmatched addresses pass untouched
T AW 20000000 07 2 PASS
T AR 30000010 0f 3 PASS
# region 0 with 256 bytes per period
T AW 10000000 0f 2 PASS
T AR 10000100 0f 3 PASS
T AW 10000200 07 3 PASS
T AR 10000300 00 2 HOLD
W 00000008 00000100 f
# region 1 with 64 bytes, first burst oversize
W 0000001c 000186a0 f
W 00000010 40000000 f
W 00000014 4000ffff f
W 00000018 00000040 f
T AW 40000000 3f 3 PASS
T AR 40000800 00 2 HOLD
W 00000018 00000040 f
# both channels pending together
D 50000000 60000000 03 2
D 70000000 80000000 ff 2

// File: project.f
design/rt_pkg.sv
design/rt_if.sv
design/rt_cfg_regs.sv
design/rt_req_decode.sv
design/rt_budget_counter.sv
design/rt_channel_gate.sv
design/axi_rt_unit.sv
sim/tb_axi_rt_unit.sv

// File: Bender.yml
package:
  name: axi_rt_unit

sources:
  - files:
      - design/rt_pkg.sv
      - design/rt_if.sv
      - design/rt_cfg_regs.sv
      - design/rt_req_decode.sv
      - design/rt_budget_counter.sv
      - design/rt_channel_gate.sv
      - design/axi_rt_unit.sv
  - target: simulation
    files:
      - sim/tb_axi_rt_unit.sv
